// File: src/anneal_config.svh
`ifndef ANNEAL_CONFIG_SVH
`define ANNEAL_CONFIG_SVH

// ######################################################################
// Problem size and datapath widths
// ######################################################################

// Number of cities in the tour, from 4 up to 2**CITY_BITS - 1.
`define CITY_NUM 12

`define CITY_BITS 7  // Width of one city index.

`define RAND_BITS 32  // Width of a Metropolis or exchange random word.

// ######################################################################
// Move buffer
// ######################################################################

`define FIFO_DEPTH 4  // Finished moves held ahead of the core.

`endif

// File: src/anneal_pkg.sv
`include "anneal_config.svh"

package anneal_pkg;

    // ##################################################################
    // Move description
    // ##################################################################

    typedef enum logic {
        TWO_OPT = 1'b0,
        OR_OPT  = 1'b1
    } move_kind_t;

    typedef logic [`CITY_BITS-1:0] city_t;

    // One move word, read according to the move kind.
    // A 2-opt move reverses the segment first..last.
    // An or-opt move takes city src out and puts it behind dst.
    typedef union packed {
        struct packed {
            city_t first;
            city_t last;
        } two_opt;
        struct packed {
            city_t src;
            city_t dst;
        } or_opt;
    } move_word_t;

    // ##################################################################
    // Random decision words
    // ##################################################################

    typedef logic [`RAND_BITS-1:0] rand_t;

endpackage

// File: src/move_proposer.sv
`timescale 1ns/1ps

`include "anneal_config.svh"

module move_proposer (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    init,
    input  logic [63:0]             seed,
    input  anneal_pkg::move_kind_t  kind,
    input  logic                    full,
    output logic                    push,
    output anneal_pkg::move_kind_t  push_kind,
    output anneal_pkg::move_word_t  push_move,
    output anneal_pkg::rand_t       push_metropolis,
    output anneal_pkg::rand_t       push_exchange
);

    import anneal_pkg::*;

    localparam city_t CITY_MAX  = city_t'(`CITY_NUM);
    localparam city_t CITY_LAST = city_t'(`CITY_NUM - 1);

    typedef enum logic [1:0] {
        DRAW_K     = 2'b00,
        DRAW_L     = 2'b01,
        DRAW_METRO = 2'b10,
        DRAW_EXCH  = 2'b11
    } state_t;

    state_t      state;
    logic        running;
    logic        active;
    move_kind_t  kind_q;
    logic [63:0] seed_q;
    logic [63:0] x1;
    logic [63:0] x2;
    logic [63:0] next_seed;
    city_t       draw;
    rand_t       rand_draw;
    city_t       k_q;
    logic        k_ok;
    logic        l_ok;
    logic        pair_bad;
    move_word_t  move_q;
    rand_t       metro_q;
    rand_t       exch_q;

    // ##################################################################
    // Xorshift generator
    // ##################################################################

    always_comb begin
        x1        = seed_q ^ (seed_q << 13);
        x2        = x1 ^ (x1 >> 7);
        next_seed = x2 ^ (x2 << 17);
    end

    assign draw      = next_seed[`CITY_BITS-1:0];  // Masked to the index width.
    assign rand_draw = next_seed[`RAND_BITS-1:0];

    // The whole machine, generator included, freezes while the FIFO is full.
    assign active = running && !full && !init;

    // ##################################################################
    // Rejection rules
    // ##################################################################

    always_comb begin
        if (kind_q == TWO_OPT) begin
            k_ok     = (draw >= city_t'(1)) && (draw <= CITY_MAX);
            l_ok     = (draw >= city_t'(1)) && (draw <= CITY_MAX);
            pair_bad = (draw == k_q);
        end else begin
            k_ok     = (draw >= city_t'(1)) && (draw <= CITY_LAST);
            l_ok     = (draw <= CITY_LAST);
            pair_bad = (draw == k_q) || (draw == k_q - city_t'(1));  // k_q is at least 1.
        end
    end

    // ##################################################################
    // Control
    // ##################################################################

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= DRAW_K;
            running <= 1'b0;
            kind_q  <= TWO_OPT;
            seed_q  <= '0;
            push    <= 1'b0;
        end else if (init) begin
            state   <= DRAW_K;
            running <= 1'b1;
            kind_q  <= kind;
            seed_q  <= seed;
            push    <= 1'b0;
        end else begin
            push <= 1'b0;
            if (active) begin
                seed_q <= next_seed;
                case (state)
                    DRAW_K: begin
                        if (k_ok) state <= DRAW_L;
                    end
                    DRAW_L: begin
                        // An out-of-range L is simply redrawn, a clash restarts at K.
                        if (l_ok) state <= pair_bad ? DRAW_K : DRAW_METRO;
                    end
                    DRAW_METRO: state <= DRAW_EXCH;
                    DRAW_EXCH: begin
                        state <= DRAW_K;
                        push  <= 1'b1;
                    end
                    default: state <= DRAW_K;
                endcase
            end
        end
    end

    // Move payload, written only on accepted draws.
    always_ff @(posedge clk) begin
        if (active) begin
            case (state)
                DRAW_K: begin
                    if (k_ok) k_q <= draw;
                end
                DRAW_L: begin
                    if (l_ok && !pair_bad) begin
                        if (kind_q == TWO_OPT) begin
                            move_q.two_opt.first <= (draw < k_q) ? draw : k_q;
                            move_q.two_opt.last  <= (draw < k_q) ? k_q : draw;
                        end else begin
                            move_q.or_opt.src <= k_q;
                            move_q.or_opt.dst <= draw;
                        end
                    end
                end
                DRAW_METRO: metro_q <= rand_draw;
                DRAW_EXCH:  exch_q  <= rand_draw;
                default: ;
            endcase
        end
    end

    assign push_kind       = kind_q;
    assign push_move       = move_q;
    assign push_metropolis = metro_q;
    assign push_exchange   = exch_q;

    // A push is only issued after four draws made while the FIFO had room.
    push_not_full_a: assert property (@(posedge clk) disable iff (reset)
        push |-> !full);

endmodule

// File: src/move_fifo.sv
`timescale 1ns/1ps

`include "anneal_config.svh"

module move_fifo (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush,
    input  logic                    push,
    input  anneal_pkg::move_kind_t  push_kind,
    input  anneal_pkg::move_word_t  push_move,
    input  anneal_pkg::rand_t       push_metropolis,
    input  anneal_pkg::rand_t       push_exchange,
    input  logic                    pop,
    output logic                    full,
    output logic                    empty,
    output anneal_pkg::move_kind_t  head_kind,
    output anneal_pkg::move_word_t  head_move,
    output anneal_pkg::rand_t       head_metropolis,
    output anneal_pkg::rand_t       head_exchange
);

    import anneal_pkg::*;

    localparam int DEPTH    = `FIFO_DEPTH;
    localparam int PTR_BITS = $clog2(DEPTH);
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    move_kind_t          kind_mem  [DEPTH];
    move_word_t          move_mem  [DEPTH];
    rand_t               metro_mem [DEPTH];
    rand_t               exch_mem  [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;

    function automatic logic [PTR_BITS-1:0] ptr_next(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (push) begin
            kind_mem[wr_ptr]  <= push_kind;
            move_mem[wr_ptr]  <= push_move;
            metro_mem[wr_ptr] <= push_metropolis;
            exch_mem[wr_ptr]  <= push_exchange;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= ptr_next(wr_ptr);
            if (pop) rd_ptr <= ptr_next(rd_ptr);
            if (push && !pop) count <= count + 1'b1;
            else if (pop && !push) count <= count - 1'b1;
        end
    end

    assign full  = (count == CNT_BITS'(DEPTH));
    assign empty = (count == '0);

    // Show-ahead head, valid whenever empty is low.
    assign head_kind       = kind_mem[rd_ptr];
    assign head_move       = move_mem[rd_ptr];
    assign head_metropolis = metro_mem[rd_ptr];
    assign head_exchange   = exch_mem[rd_ptr];

    no_pop_empty_a: assert property (@(posedge clk) disable iff (reset)
        pop |-> !empty);
    no_push_full_a: assert property (@(posedge clk) disable iff (reset)
        push |-> !full);

endmodule

// File: src/move_judge.sv
`timescale 1ns/1ps

module move_judge (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    step,
    input  logic                    empty,
    input  anneal_pkg::move_kind_t  head_kind,
    input  anneal_pkg::move_word_t  head_move,
    input  anneal_pkg::rand_t       head_metropolis,
    input  anneal_pkg::rand_t       head_exchange,
    input  anneal_pkg::rand_t       metropolis_threshold,
    input  anneal_pkg::rand_t       exchange_threshold,
    output logic                    pop,
    output logic                    move_valid,
    output anneal_pkg::move_kind_t  move_kind,
    output anneal_pkg::city_t       city_a,
    output anneal_pkg::city_t       city_b,
    output logic                    accept_move,
    output logic                    accept_exchange,
    output logic                    underflow
);

    import anneal_pkg::*;

    city_t dec_a;
    city_t dec_b;

    assign pop = step && !empty;  // A step on an empty FIFO pops nothing.

    // ##################################################################
    // Move decode
    // ##################################################################

    always_comb begin
        if (head_kind == TWO_OPT) begin
            dec_a = head_move.two_opt.first;
            dec_b = head_move.two_opt.last;
        end else begin
            dec_a = head_move.or_opt.src;
            dec_b = head_move.or_opt.dst;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            move_valid <= 1'b0;
            underflow  <= 1'b0;
        end else begin
            move_valid <= pop;
            if (step && empty) underflow <= 1'b1;  // Sticky until reset.
        end
    end

    // Decision payload, sampled with the thresholds on the step cycle.
    always_ff @(posedge clk) begin
        if (pop) begin
            move_kind       <= head_kind;
            city_a          <= dec_a;
            city_b          <= dec_b;
            accept_move     <= head_metropolis < metropolis_threshold;
            accept_exchange <= head_exchange < exchange_threshold;
        end
    end

    // The core may only step while a move is buffered.
    step_has_move_a: assert property (@(posedge clk) disable iff (reset)
        step |-> !empty);

endmodule

// File: src/move_gen_top.sv
`timescale 1ns/1ps

module move_gen_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    init,
    input  logic [63:0]             seed,
    input  anneal_pkg::move_kind_t  kind,
    input  logic                    step,
    input  anneal_pkg::rand_t       metropolis_threshold,
    input  anneal_pkg::rand_t       exchange_threshold,
    output logic                    move_ready,
    output logic                    move_valid,
    output anneal_pkg::move_kind_t  move_kind,
    output anneal_pkg::city_t       city_a,
    output anneal_pkg::city_t       city_b,
    output logic                    accept_move,
    output logic                    accept_exchange,
    output logic                    underflow
);

    import anneal_pkg::*;

    logic       push;
    move_kind_t push_kind;
    move_word_t push_move;
    rand_t      push_metropolis;
    rand_t      push_exchange;
    logic       full;
    logic       empty;
    logic       pop;
    move_kind_t head_kind;
    move_word_t head_move;
    rand_t      head_metropolis;
    rand_t      head_exchange;

    move_proposer proposer_i (
        .clk             (clk),
        .reset           (reset),
        .init            (init),
        .seed            (seed),
        .kind            (kind),
        .full            (full),
        .push            (push),
        .push_kind       (push_kind),
        .push_move       (push_move),
        .push_metropolis (push_metropolis),
        .push_exchange   (push_exchange)
    );

    // A new seed makes every buffered move stale.
    move_fifo fifo_i (
        .clk             (clk),
        .reset           (reset),
        .flush           (init),
        .push            (push),
        .push_kind       (push_kind),
        .push_move       (push_move),
        .push_metropolis (push_metropolis),
        .push_exchange   (push_exchange),
        .pop             (pop),
        .full            (full),
        .empty           (empty),
        .head_kind       (head_kind),
        .head_move       (head_move),
        .head_metropolis (head_metropolis),
        .head_exchange   (head_exchange)
    );

    move_judge judge_i (
        .clk                  (clk),
        .reset                (reset),
        .step                 (step),
        .empty                (empty),
        .head_kind            (head_kind),
        .head_move            (head_move),
        .head_metropolis      (head_metropolis),
        .head_exchange        (head_exchange),
        .metropolis_threshold (metropolis_threshold),
        .exchange_threshold   (exchange_threshold),
        .pop                  (pop),
        .move_valid           (move_valid),
        .move_kind            (move_kind),
        .city_a               (city_a),
        .city_b               (city_b),
        .accept_move          (accept_move),
        .accept_exchange      (accept_exchange),
        .underflow            (underflow)
    );

    assign move_ready = !empty;

endmodule

// File: dv/tb_move_gen.sv
`timescale 1ns/1ps

`include "anneal_config.svh"

module tb_move_gen;

    import anneal_pkg::*;

    logic        clk;
    logic        reset;
    logic        init;
    logic [63:0] seed;
    move_kind_t  kind;
    logic        step;
    rand_t       metropolis_threshold;
    rand_t       exchange_threshold;
    logic        move_ready;
    logic        move_valid;
    move_kind_t  move_kind;
    city_t       city_a;
    city_t       city_b;
    logic        accept_move;
    logic        accept_exchange;
    logic        underflow;

    logic [63:0] rec_seed[$];
    move_kind_t  rec_kind[$];
    rand_t       rec_thr_m[$];
    rand_t       rec_thr_e[$];
    int          rec_moves[$];
    int          rec_gap[$];

    move_kind_t  exp_kind[$];
    city_t       exp_a[$];
    city_t       exp_b[$];
    logic        exp_m[$];
    logic        exp_e[$];

    int          cycles = 0;
    int          cycle_limit = 0;
    int          error_count = 0;

    move_gen_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Every move waits at most this long, gaps included.
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: no result after %0d clock cycles.", cycles);
            $display("TEST FAIL");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // ##################################################################
    // Reference rules for moves and decisions
    // ##################################################################

    function automatic logic [63:0] xorshift(input logic [63:0] s);
        logic [63:0] t;
        t = s ^ (s << 13);
        t = t ^ (t >> 7);
        return t ^ (t << 17);
    endfunction

    function automatic bit source_ok(input move_kind_t k, input int c);
        if (k == TWO_OPT) return c >= 1 && c <= `CITY_NUM;
        return c >= 1 && c <= `CITY_NUM - 1;
    endfunction

    function automatic bit target_ok(input move_kind_t k, input int c);
        if (k == TWO_OPT) return c >= 1 && c <= `CITY_NUM;
        return c <= `CITY_NUM - 1;
    endfunction

    function automatic bit pair_clash(input move_kind_t k, input int src, input int dst);
        if (k == TWO_OPT) return dst == src;
        return dst == src || dst == src - 1;
    endfunction

    task automatic build_expected(input logic [63:0] s0, input move_kind_t k,
                                  input rand_t thr_m, input rand_t thr_e, input int n);
        logic [63:0] s;
        int          a;
        int          b;
        rand_t       wm;
        rand_t       we;
        s = s0;
        for (int i = 0; i < n; i++) begin
            do begin
                do begin
                    s = xorshift(s);
                    a = int'(s[`CITY_BITS-1:0]);
                end while (!source_ok(k, a));
                do begin
                    s = xorshift(s);
                    b = int'(s[`CITY_BITS-1:0]);
                end while (!target_ok(k, b));
            end while (pair_clash(k, a, b));
            s = xorshift(s);
            wm = s[`RAND_BITS-1:0];
            s = xorshift(s);
            we = s[`RAND_BITS-1:0];
            exp_kind.push_back(k);
            exp_a.push_back(city_t'((k == TWO_OPT && b < a) ? b : a));
            exp_b.push_back(city_t'((k == TWO_OPT && b < a) ? a : b));
            exp_m.push_back(wm < thr_m);
            exp_e.push_back(we < thr_e);
        end
    endtask

    // ##################################################################
    // Checks
    // ##################################################################

    task automatic report_mismatch(input string msg);
        error_count++;
        $display("ERR at %0t ns: %s", $time, msg);
        $display("TEST FAIL");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic check_move(input move_kind_t k, input city_t a, input city_t b);
        if (k == TWO_OPT && !(city_a >= 1 && city_a < city_b && city_b <= `CITY_NUM))
            report_mismatch($sformatf("2-opt bounds %0d %0d out of range", city_a, city_b));
        if (k == OR_OPT && !(source_ok(k, city_a) && target_ok(k, city_b)
                && !pair_clash(k, city_a, city_b)))
            report_mismatch($sformatf("or-opt pair %0d %0d is illegal", city_a, city_b));
        if (move_kind !== k || city_a !== a || city_b !== b)
            report_mismatch($sformatf("move %s %0d %0d, expected %s %0d %0d",
                move_kind.name(), city_a, city_b, k.name(), a, b));
    endtask

    task automatic check_decision(input logic m, input logic e);
        if (accept_move !== m || accept_exchange !== e)
            report_mismatch($sformatf("accept %b %b, expected %b %b",
                accept_move, accept_exchange, m, e));
    endtask

    // ##################################################################
    // Stimulus
    // ##################################################################

    task automatic idle_cycle();
        @(negedge clk);
        if (move_valid !== 1'b0) report_mismatch("move_valid without a step");
        if (underflow !== 1'b0) report_mismatch("underflow raised");
    endtask

    task automatic step_and_check();
        while (move_ready !== 1'b1) idle_cycle();
        step = 1'b1;
        @(negedge clk);
        step = 1'b0;
        if (move_valid !== 1'b1) report_mismatch("move_valid missing one cycle after step");
        check_move(exp_kind.pop_front(), exp_a.pop_front(), exp_b.pop_front());
        check_decision(exp_m.pop_front(), exp_e.pop_front());
    endtask

    task automatic read_patterns();
        int    fd;
        int    k;
        int    n;
        int    g;
        int    total;
        string line;
        logic [63:0] s;
        rand_t tm;
        rand_t te;
        total = 0;
        fd = $fopen("dv/move_patterns.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the pattern file dv/move_patterns.txt.");
            $display("TEST FAIL");
            $fatal(1, "no stimulus");
        end
        while ($fgets(line, fd)) begin
            if (line.len() > 1 && line[0] != "#"
                    && $sscanf(line, "%h %d %h %h %d %d", s, k, tm, te, n, g) == 6) begin
                rec_seed.push_back(s);
                rec_kind.push_back(move_kind_t'(k[0]));
                rec_thr_m.push_back(tm);
                rec_thr_e.push_back(te);
                rec_moves.push_back(n);
                rec_gap.push_back(g);
                total += n;
            end
        end
        $fclose(fd);
        cycle_limit = total * 200;
    endtask

    initial begin
        reset = 1'b1;
        init = 1'b0;
        seed = '0;
        kind = TWO_OPT;
        step = 1'b0;
        metropolis_threshold = '0;
        exchange_threshold = '0;
        void'($urandom(32'h1fce));
        read_patterns();
        repeat (2) @(negedge clk);
        reset = 1'b0;
        // Each new init also throws away whatever the last record left buffered.
        foreach (rec_seed[r]) begin
            init = 1'b1;
            seed = rec_seed[r];
            kind = rec_kind[r];
            metropolis_threshold = rec_thr_m[r];
            exchange_threshold = rec_thr_e[r];
            build_expected(rec_seed[r], rec_kind[r], rec_thr_m[r], rec_thr_e[r], rec_moves[r]);
            idle_cycle();
            // The flushed FIFO stays empty until the proposer finishes a new move.
            if (move_ready !== 1'b0) report_mismatch("move_ready high right after init");
            init = 1'b0;
            for (int i = 0; i < rec_moves[r]; i++) begin
                repeat ($urandom % (rec_gap[r] + 1)) idle_cycle();
                step_and_check();
            end
        end
        idle_cycle();
        if (error_count == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("TEST FAIL");
            $fatal(1, "checks failed");
        end
    end

endmodule

// File: dv/move_patterns.txt
# Columns: seed (hex, 64 bit), kind (0 = 2-opt, 1 = or-opt),
# Metropolis threshold (hex), exchange threshold (hex), moves, longest step gap in cycles.
#
# Plain 2-opt runs with back-to-back steps.
0123456789abcdef 0 80000000 80000000 8 0
9e3779b97f4a7c15 0 40000000 c0000000 6 3
#
# Plain or-opt runs.
d1b54a32d192ed03 1 80000000 80000000 8 0
00000000deadbeef 1 20000000 e0000000 6 5
#
# Thresholds at the ends of the range.
5851f42d4c957f2d 0 00000000 00000000 6 2
14057b7ef767814f 1 00000000 ffffffff 6 2
2545f4914f6cdd1d 0 ffffffff ffffffff 6 1
bf58476d1ce4e5b9 1 ffffffff 00000000 6 1
#
# Long idle gaps let the FIFO fill and stall the proposer.
94d049bb133111eb 0 60000000 a0000000 5 60
0000000000000001 1 a0000000 60000000 5 60
#
# Short records in a row, each init lands on a partly filled FIFO.
c2b2ae3d27d4eb4f 0 80000000 80000000 2 20
165667b19e3779f9 1 80000000 80000000 1 20
27d4eb2f165667c5 0 80000000 80000000 3 40
ff51afd7ed558ccd 1 80000000 80000000 2 10
#
# Same seed as the first record, now with spaced steps.
0123456789abcdef 0 80000000 80000000 8 25
#
# Same seed again, other kind.
0123456789abcdef 1 7fffffff 80000001 6 8
#
# Mixed spacing to close the run.
c4ceb9fe1a85ec53 1 10000000 f0000000 6 15
87c37b91114253d5 0 f0000000 10000000 6 15
4cf5ad432745937f 0 55555555 aaaaaaaa 4 0
52dce729da3ed1f3 1 aaaaaaaa 55555555 4 0

// File: flist.f
+incdir+src
src/anneal_pkg.sv
src/move_proposer.sv
src/move_fifo.sv
src/move_judge.sv
src/move_gen_top.sv
dv/tb_move_gen.sv

// File: Bender.yml
package:
  name: move_gen

sources:
  - include_dirs:
      - src
    files:
      - src/anneal_pkg.sv
      - src/move_proposer.sv
      - src/move_fifo.sv
      - src/move_judge.sv
      - src/move_gen_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - dv/tb_move_gen.sv
